//--- cpuCore.f
+incdir+hw
hw/cpuPkg.sv
hw/stageRegister.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/cpuCore.sv
tb/cpuCoreAssertions.sv
tb/cpuCoreTb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f cpuCore.f \
    --top-module cpuCoreTb \
    -o cpuCoreSim

./obj_dir/cpuCoreSim

//--- tb/cpuCoreTb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuCoreTb;

    localparam int PROG_LEN = 24;
    localparam int HALT_IDX = PROG_LEN - 1;
    // instruction kinds of the generator
    localparam int K_ALU = 0;
    localparam int K_ALUI = 1;
    localparam int K_LW = 2;
    localparam int K_SW = 3;
    localparam int K_BR = 4;
    localparam int K_HALT = 5;

    logic clk_in;
    logic rst_in;
    cpuPkg::wordT imemAddr;
    cpuPkg::wordT imemData;
    logic memReq;
    logic memWrite;
    cpuPkg::wordT memAddr;
    cpuPkg::wordT memWdata;
    logic memAck;
    cpuPkg::wordT memRdata;

    int seed;
    cpuPkg::wordT imem [PROG_LEN];
    cpuPkg::wordT dmem [16];
    cpuPkg::wordT modelMem [16];
    int kind [PROG_LEN];
    int op [PROG_LEN];
    int rd [PROG_LEN];
    int rs1 [PROG_LEN];
    int rs2 [PROG_LEN];
    int imm [PROG_LEN];
    // expected stores from the ISA model in program order
    cpuPkg::wordT expAddr [$];
    cpuPkg::wordT expData [$];
    bit expLoad [$];
    int storeCount;
    int delayCnt;
    cpuPkg::wordT fetchAddr;

    cpuCore DUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    ////////////////////
    // error reporting
    ////////////////////
    task automatic reportFail(string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportTimeout(string what);
        $display("timed out waiting for %s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkStore(cpuPkg::wordT addr, cpuPkg::wordT data,
        cpuPkg::wordT eAddr, cpuPkg::wordT eData);
        if (addr !== eAddr || data !== eData)
            reportFail($sformatf("store %0d got %h <= %h, expected %h <= %h",
                storeCount, addr, data, eAddr, eData));
    endtask

    task automatic checkRead(cpuPkg::wordT got, cpuPkg::wordT exp);
        if (got !== exp)
            reportFail($sformatf("loaded value %h, expected %h", got, exp));
    endtask

    task automatic checkReset(logic req, cpuPkg::wordT addr);
        if (req !== 1'b0 || addr !== `RESET_PC)
            reportFail($sformatf("after reset memReq=%b imemAddr=%h", req, addr));
    endtask

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // reference ALU straight from the ISA text
    function automatic cpuPkg::wordT aluModel(int f, cpuPkg::wordT a, cpuPkg::wordT b);
        case (f)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function automatic cpuPkg::wordT encode(int i);
        logic [9:0] rFields [8];
        logic [11:0] i12;
        logic [12:0] bo;
        // funct7 and funct3 in model op order
        rFields = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004, 10'h002, 10'h001, 10'h005};
        i12 = imm[i][11:0];
        bo = imm[i][12:0];
        case (kind[i])
            K_ALU: return {rFields[op[i]][9:3], 5'(rs2[i]), 5'(rs1[i]), rFields[op[i]][2:0],
                5'(rd[i]), 7'h33};
            K_ALUI: return {i12, 5'(rs1[i]), 3'b000, 5'(rd[i]), 7'h13};
            K_LW: return {i12, 5'd0, 3'b010, 5'(rd[i]), 7'h03};
            K_SW: return {i12[11:5], 5'(rs2[i]), 5'd0, 3'b010, i12[4:0], 7'h23};
            K_BR: return {bo[12], bo[10:5], 5'(rs2[i]), 5'(rs1[i]), 2'b00, 1'(op[i]),
                bo[4:1], bo[11], 7'h63};
            default: return 32'h0000_006f;
        endcase
    endfunction

    ////////////////////
    // program and model
    ////////////////////
    task automatic genProgram(int p);
        int k;
        for (int i = 0; i < HALT_IDX; i++) begin
            k = rnd(8);
            rd[i] = 1 + rnd(7);
            rs1[i] = rnd(8);
            rs2[i] = rnd(8);
            op[i] = rnd(8);
            imm[i] = 4 * rnd(16);
            if (k < 2 || (k == 6 && i > 20)) begin
                kind[i] = K_ALU;
            end else if (k == 2) begin
                kind[i] = K_ALUI;
                imm[i] = rnd(4096) - 2048;
            end else if (k == 3) begin
                kind[i] = K_LW;
            end else if (k == 6) begin
                kind[i] = K_BR;
                op[i] = rnd(2);
                imm[i] = rnd(2) ? 12 : 8;
            end else begin
                kind[i] = K_SW;
            end
            imem[i] = encode(i);
        end
        kind[HALT_IDX] = K_HALT;
        imem[HALT_IDX] = encode(HALT_IDX);
        // fill from the full byte address and the program number
        for (int w = 0; w < 16; w++) begin
            dmem[w] = cpuPkg::wordT'(w * 4) * 32'h9e37_79b9 + cpuPkg::wordT'(p);
            modelMem[w] = dmem[w];
        end
    endtask

    task automatic runModel();
        cpuPkg::wordT r [8];
        bit fromLoad [8];
        bit taken;
        int pc;
        r = '{default: '0};
        fromLoad = '{default: 1'b0};
        pc = 0;
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        while (pc != HALT_IDX) begin
            taken = 1'b0;
            case (kind[pc])
                K_ALU: r[rd[pc]] = aluModel(op[pc], r[rs1[pc]], r[rs2[pc]]);
                K_ALUI: r[rd[pc]] = r[rs1[pc]] + cpuPkg::wordT'(imm[pc]);
                K_LW: r[rd[pc]] = modelMem[imm[pc] / 4];
                K_SW: begin
                    modelMem[imm[pc] / 4] = r[rs2[pc]];
                    expAddr.push_back(cpuPkg::wordT'(imm[pc]));
                    expData.push_back(r[rs2[pc]]);
                    expLoad.push_back(fromLoad[rs2[pc]]);
                end
                default: taken = (r[rs1[pc]] == r[rs2[pc]]) ^ (op[pc] == 1);
            endcase
            if (kind[pc] inside {K_ALU, K_ALUI, K_LW})
                fromLoad[rd[pc]] = (kind[pc] == K_LW);
            pc = taken ? pc + imm[pc] / 4 : pc + 1;
        end
    endtask

    task automatic logStore(cpuPkg::wordT addr, cpuPkg::wordT data);
        if (storeCount >= expAddr.size())
            reportFail($sformatf("unexpected extra store %h <= %h", addr, data));
        // store data that came straight from a load
        if (expLoad[storeCount])
            checkRead(data, expData[storeCount]);
        checkStore(addr, data, expAddr[storeCount], expData[storeCount]);
        storeCount++;
    endtask

    ////////////////////
    // memories
    ////////////////////
    // one-cycle instruction read and a data port with random phase delays
    initial begin
        fetchAddr = `RESET_PC;
        delayCnt = 0;
        forever begin
            @(posedge clk_in);
            #5;
            imemData = (fetchAddr < PROG_LEN * 4) ? imem[fetchAddr[6:2]] : `NOP_INSTR;
            fetchAddr = imemAddr;
            if ((memReq && !memAck) || (!memReq && memAck)) begin
                if (delayCnt > 0) begin
                    delayCnt--;
                end else begin
                    if (memAck) begin
                        memAck = 1'b0;
                    end else begin
                        if (memWrite) begin
                            dmem[memAddr[5:2]] = memWdata;
                            logStore(memAddr, memWdata);
                        end
                        memRdata = dmem[memAddr[5:2]];
                        memAck = 1'b1;
                    end
                    delayCnt = rnd(4);
                end
            end
        end
    end

    task automatic applyReset();
        @(posedge clk_in);
        #5 rst_in = 1'b1;
        repeat (10) @(posedge clk_in);
        #5 checkReset(memReq, imemAddr);
        rst_in = 1'b0;
    endtask

    initial begin
        int cycles;
        seed = 32'h449c_a265;
        rst_in = 1'b1;
        imemData = `NOP_INSTR;
        memAck = 1'b0;
        memRdata = '0;
        storeCount = 0;
        for (int p = 0; p < 8; p++) begin
            genProgram(p);
            runModel();
            storeCount = 0;
            applyReset();
            cycles = 0;
            while (storeCount < expAddr.size()) begin
                @(posedge clk_in);
                cycles++;
                if (cycles > 4000)
                    reportTimeout($sformatf("store %0d of program %0d", storeCount, p));
            end
            // late stores during the halt spin fail in logStore
            repeat (60) @(posedge clk_in);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/cpuCoreAssertions.sv
`timescale 1ns/1ps

module cpuCoreAssertions (
    input logic clk_in,
    input logic rst_in,
    input logic memReq,
    input logic memAck,
    input cpuPkg::wordT memAddr,
    input cpuPkg::wordT memWdata
);

    // req held until the memory answers
    reqHeld: assert property (@(posedge clk_in) disable iff (rst_in)
        memReq && !memAck |=> memReq) else $error("memReq dropped before memAck");

    // address and write data frozen across the request
    reqStable: assert property (@(posedge clk_in) disable iff (rst_in)
        memReq ##1 memReq |-> $stable(memAddr) && $stable(memWdata))
        else $error("memAddr or memWdata changed while memReq high");

    // no new request until the last ack is gone
    // req rises just after the edge where ack was last sampled
    noEarlyReq: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(memReq) |-> !$past(memAck)) else $error("memReq rose while memAck high");

    afterReset: assert property (@(posedge clk_in)
        rst_in |=> !memReq) else $error("memReq high after reset");

endmodule

bind cpuCore cpuCoreAssertions dataPortChecks (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .memReq(memReq),
    .memAck(memAck),
    .memAddr(memAddr),
    .memWdata(memWdata)
);

//--- hw/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input logic clk_in,
    input logic rst_in,
    output cpuPkg::wordT imemAddr,
    input cpuPkg::wordT imemData,
    output logic memReq,
    output logic memWrite,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT memWdata,
    input logic memAck,
    input cpuPkg::wordT memRdata
);

    // fetch to decode
    cpuPkg::wordT fetchInstr;
    cpuPkg::wordT fetchPc;
    logic fetchValid;
    logic fetchStall;

    // decode to execute
    cpuPkg::d2eT d2eNext;
    cpuPkg::d2eT d2eQ;
    logic d2eNextValid;
    logic d2eQValid;
    logic decStall;
    logic d2eFlush;

    // execute to writeback
    cpuPkg::e2wT e2wNext;
    cpuPkg::e2wT e2wQ;
    logic e2wNextValid;
    logic e2wQValid;

    // bypass and control
    cpuPkg::regIdxT exDst;
    cpuPkg::wordT exData;
    logic exDataReady;
    logic redirect;
    cpuPkg::wordT redirectPc;
    cpuPkg::regIdxT wbDst;
    cpuPkg::wordT wbData;
    logic wbEnable;
    logic memBusy;

    // data access freezes fetch too
    assign fetchStall = decStall | memBusy;
    assign d2eFlush = redirect | decStall;

    fetchStage fetch (
        .clk_in(clk_in), .rst_in(rst_in),
        .stall(fetchStall), .redirect(redirect), .redirectPc(redirectPc),
        .imemAddr(imemAddr), .imemData(imemData),
        .instr(fetchInstr), .pc(fetchPc), .instrValid(fetchValid)
    );

    decodeStage decode (
        .clk_in(clk_in), .rst_in(rst_in),
        .instr(fetchInstr), .pc(fetchPc), .instrValid(fetchValid),
        .exDst(exDst), .exData(exData), .exDataReady(exDataReady),
        .wbDst(wbDst), .wbData(wbData), .wbEnable(wbEnable),
        .d2eOut(d2eNext), .d2eValid(d2eNextValid), .stall(decStall)
    );

    stageRegister #(.payloadT(cpuPkg::d2eT)) d2eReg (
        .clk_in(clk_in), .rst_in(rst_in),
        .hold(memBusy), .flush(d2eFlush),
        .dataIn(d2eNext), .validIn(d2eNextValid),
        .dataOut(d2eQ), .validOut(d2eQValid)
    );

    executeStage execute (
        .d2eIn(d2eQ), .d2eValid(d2eQValid),
        .e2wOut(e2wNext), .e2wValid(e2wNextValid),
        .exDst(exDst), .exData(exData), .exDataReady(exDataReady),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    // nothing younger than execute gets annulled here
    stageRegister #(.payloadT(cpuPkg::e2wT)) e2wReg (
        .clk_in(clk_in), .rst_in(rst_in),
        .hold(memBusy), .flush(1'b0),
        .dataIn(e2wNext), .validIn(e2wNextValid),
        .dataOut(e2wQ), .validOut(e2wQValid)
    );

    memWriteback writeback (
        .clk_in(clk_in), .rst_in(rst_in),
        .e2wIn(e2wQ), .e2wValid(e2wQValid),
        .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
        .memAck(memAck), .memRdata(memRdata), .memBusy(memBusy),
        .wbDst(wbDst), .wbData(wbData), .wbEnable(wbEnable)
    );

endmodule

//--- hw/memWriteback.sv
`timescale 1ns/1ps

module memWriteback (
    input logic clk_in,
    input logic rst_in,
    input cpuPkg::e2wT e2wIn,
    input logic e2wValid,
    output logic memReq,
    output logic memWrite,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT memWdata,
    input logic memAck,
    input cpuPkg::wordT memRdata,
    output logic memBusy,
    output cpuPkg::regIdxT wbDst,
    output cpuPkg::wordT wbData,
    output logic wbEnable
);

    typedef enum logic [1:0] {
        IDLE, WAITACK, WAITRELEASE
    } memStateT;

    memStateT memState;
    cpuPkg::wordT rdataQ;
    logic isMem;
    logic memDone;
    logic retire;

    assign isMem = e2wValid
        && (e2wIn.iType == cpuPkg::LOAD || e2wIn.iType == cpuPkg::STORE);

    // handshake finishes once ack falls after req dropped
    assign memDone = memState == WAITRELEASE && !memAck;

    ////////////////////
    // four-phase FSM
    ////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            memState <= IDLE;
        end else begin
            case (memState)
                // wait for ack low before a new req
                IDLE: if (isMem && !memAck) memState <= WAITACK;
                WAITACK: if (memAck) memState <= WAITRELEASE;
                WAITRELEASE: if (!memAck) memState <= IDLE;
                default: memState <= IDLE;
            endcase
        end
    end

    // read data only valid while ack is high
    always_ff @(posedge clk_in) begin
        if (memState == WAITACK && memAck) begin
            rdataQ <= memRdata;
        end
    end

    // e2w is frozen while busy, so addr and wdata stay stable
    assign memReq = memState == WAITACK;
    assign memWrite = e2wIn.iType == cpuPkg::STORE;
    assign memAddr = e2wIn.addr;
    assign memWdata = e2wIn.data;

    // freezes the pipe until the access completes
    assign memBusy = isMem && !memDone;

    ////////////////////
    // writeback
    ////////////////////
    assign retire = e2wValid && (!isMem || memDone);
    assign wbEnable = retire && e2wIn.dst != '0
        && e2wIn.iType inside {cpuPkg::ALU, cpuPkg::ALUI, cpuPkg::JAL, cpuPkg::LOAD};
    assign wbDst = e2wIn.dst;
    assign wbData = (e2wIn.iType == cpuPkg::LOAD) ? rdataQ : e2wIn.data;

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input cpuPkg::d2eT d2eIn,
    input logic d2eValid,
    output cpuPkg::e2wT e2wOut,
    output logic e2wValid,
    output cpuPkg::regIdxT exDst,
    output cpuPkg::wordT exData,
    output logic exDataReady,
    output logic redirect,
    output cpuPkg::wordT redirectPc
);

    cpuPkg::decodedInstT dInst;
    cpuPkg::wordT opB;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT linkPc;
    cpuPkg::wordT nextPc;
    cpuPkg::wordT resultData;
    logic taken;

    assign dInst = d2eIn.dInst;

    // addi takes the immediate as second operand
    assign opB = (dInst.iType == cpuPkg::ALUI) ? dInst.imm : d2eIn.rVal2;

    ////////////////////
    // alu
    ////////////////////
    always_comb begin
        case (dInst.aluFunc)
            cpuPkg::ADD: aluResult = d2eIn.rVal1 + opB;
            cpuPkg::SUB: aluResult = d2eIn.rVal1 - opB;
            cpuPkg::AND: aluResult = d2eIn.rVal1 & opB;
            cpuPkg::OR: aluResult = d2eIn.rVal1 | opB;
            cpuPkg::XOR: aluResult = d2eIn.rVal1 ^ opB;
            // signed compare, zero extended flag
            cpuPkg::SLT: aluResult = cpuPkg::wordT'($signed(d2eIn.rVal1) < $signed(opB));
            cpuPkg::SLL: aluResult = d2eIn.rVal1 << opB[4:0];
            cpuPkg::SRL: aluResult = d2eIn.rVal1 >> opB[4:0];
            default: aluResult = '0;
        endcase
    end

    ////////////////////
    // branch and next pc
    ////////////////////
    always_comb begin
        case (dInst.brFunc)
            cpuPkg::EQ: taken = d2eIn.rVal1 == d2eIn.rVal2;
            cpuPkg::NE: taken = d2eIn.rVal1 != d2eIn.rVal2;
            default: taken = 1'b0;
        endcase
    end

    assign linkPc = d2eIn.pc + 32'd4;
    assign nextPc = (dInst.iType == cpuPkg::JAL || (dInst.iType == cpuPkg::BRANCH && taken))
        ? d2eIn.pc + dInst.imm : linkPc;

    // anything off the sequential path annuls the two younger slots
    assign redirect = d2eValid && nextPc != linkPc;
    assign redirectPc = nextPc;

    // jal writes its link
    assign resultData = (dInst.iType == cpuPkg::JAL) ? linkPc : aluResult;

    // store data rides in the data field, address is rs1 + imm for lw and sw
    assign e2wOut = '{
        pc: d2eIn.pc,
        iType: dInst.iType,
        dst: dInst.dst,
        data: (dInst.iType == cpuPkg::STORE) ? d2eIn.rVal2 : resultData,
        addr: d2eIn.rVal1 + dInst.imm
    };
    assign e2wValid = d2eValid;

    // bypass to decode, load data not ready yet
    assign exDst = d2eValid ? dInst.dst : '0;
    assign exData = resultData;
    assign exDataReady = d2eValid && dInst.iType != cpuPkg::LOAD;

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decodeStage (
    input logic clk_in,
    input logic rst_in,
    input cpuPkg::wordT instr,
    input cpuPkg::wordT pc,
    input logic instrValid,
    input cpuPkg::regIdxT exDst,
    input cpuPkg::wordT exData,
    input logic exDataReady,
    input cpuPkg::regIdxT wbDst,
    input cpuPkg::wordT wbData,
    input logic wbEnable,
    output cpuPkg::d2eT d2eOut,
    output logic d2eValid,
    output logic stall
);

    cpuPkg::wordT regFile [`NUM_REGS];
    cpuPkg::decodedInstT dInst;
    cpuPkg::aluFuncT rFunc;
    cpuPkg::wordT rVal1;
    cpuPkg::wordT rVal2;
    cpuPkg::wordT immI;
    cpuPkg::wordT immS;
    cpuPkg::wordT immB;
    cpuPkg::wordT immJ;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended immediates per format
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    // decoder
    ////////////////////

    // register-register op from funct7 and funct3
    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: rFunc = cpuPkg::ADD;
            10'b0100000_000: rFunc = cpuPkg::SUB;
            10'b0000000_001: rFunc = cpuPkg::SLL;
            10'b0000000_010: rFunc = cpuPkg::SLT;
            10'b0000000_100: rFunc = cpuPkg::XOR;
            10'b0000000_101: rFunc = cpuPkg::SRL;
            10'b0000000_110: rFunc = cpuPkg::OR;
            10'b0000000_111: rFunc = cpuPkg::AND;
            default: rFunc = cpuPkg::NOPA;
        endcase
    end

    always_comb begin
        // anything unmatched runs as a nop
        dInst.iType = cpuPkg::UNSUPPORTED;
        dInst.aluFunc = cpuPkg::NOPA;
        dInst.brFunc = cpuPkg::NOPB;
        dInst.dst = '0;
        dInst.src1 = '0;
        dInst.src2 = '0;
        dInst.imm = '0;
        case (opcode)
            7'b0110011: if (rFunc != cpuPkg::NOPA) begin
                dInst.iType = cpuPkg::ALU;
                dInst.aluFunc = rFunc;
                dInst.dst = instr[11:7];
                dInst.src1 = instr[19:15];
                dInst.src2 = instr[24:20];
            end
            // addi only
            7'b0010011: if (funct3 == 3'b000) begin
                dInst.iType = cpuPkg::ALUI;
                dInst.aluFunc = cpuPkg::ADD;
                dInst.dst = instr[11:7];
                dInst.src1 = instr[19:15];
                dInst.imm = immI;
            end
            // lw
            7'b0000011: if (funct3 == 3'b010) begin
                dInst.iType = cpuPkg::LOAD;
                dInst.dst = instr[11:7];
                dInst.src1 = instr[19:15];
                dInst.imm = immI;
            end
            // sw
            7'b0100011: if (funct3 == 3'b010) begin
                dInst.iType = cpuPkg::STORE;
                dInst.src1 = instr[19:15];
                dInst.src2 = instr[24:20];
                dInst.imm = immS;
            end
            // beq and bne
            7'b1100011: if (funct3 == 3'b000 || funct3 == 3'b001) begin
                dInst.iType = cpuPkg::BRANCH;
                dInst.brFunc = funct3[0] ? cpuPkg::NE : cpuPkg::EQ;
                dInst.src1 = instr[19:15];
                dInst.src2 = instr[24:20];
                dInst.imm = immB;
            end
            7'b1101111: begin
                dInst.iType = cpuPkg::JAL;
                dInst.dst = instr[11:7];
                dInst.imm = immJ;
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // register file
    ////////////////////

    // x0 is never written, so it reads zero
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbEnable && wbDst != '0) begin
            regFile[wbDst] <= wbData;
        end
    end

    // execute result first, then the retiring writeback
    function automatic cpuPkg::wordT readOperand(cpuPkg::regIdxT src);
        cpuPkg::wordT value;
        value = regFile[src];
        if (exDataReady && exDst != '0 && exDst == src)
            value = exData;
        else if (wbEnable && wbDst != '0 && wbDst == src)
            value = wbData;
        return value;
    endfunction

    always_comb begin
        rVal1 = readOperand(dInst.src1);
        rVal2 = readOperand(dInst.src2);
    end

    // load in execute feeding a source, no data until writeback
    assign stall = instrValid && exDst != '0 && !exDataReady
        && (exDst == dInst.src1 || exDst == dInst.src2);

    assign d2eOut = '{pc: pc, dInst: dInst, rVal1: rVal1, rVal2: rVal2};
    assign d2eValid = instrValid;

endmodule

//--- hw/fetchStage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchStage (
    input logic clk_in,
    input logic rst_in,
    input logic stall,
    input logic redirect,
    input cpuPkg::wordT redirectPc,
    output cpuPkg::wordT imemAddr,
    input cpuPkg::wordT imemData,
    output cpuPkg::wordT instr,
    output cpuPkg::wordT pc,
    output logic instrValid
);

    // address of the fetch being issued
    cpuPkg::wordT pcReg;
    // copy of the returned word while decode is stalled
    cpuPkg::wordT instrHold;
    logic held;

    assign imemAddr = pcReg;

    // memory keeps reading pcReg during a stall, so the stalled word comes from the hold copy
    assign instr = !instrValid ? `NOP_INSTR : (held ? instrHold : imemData);

    ////////////////////
    // pc and valid flag
    ////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pcReg <= `RESET_PC;
            instrValid <= 1'b0;
            held <= 1'b0;
        end else if (redirect) begin
            // redirect beats stall, wrong-path word returned next is dropped
            pcReg <= redirectPc;
            instrValid <= 1'b0;
            held <= 1'b0;
        end else if (stall) begin
            held <= 1'b1;
        end else begin
            pcReg <= pcReg + 32'd4;
            instrValid <= 1'b1;
            held <= 1'b0;
        end
    end

    // pc of the word arriving next cycle
    always_ff @(posedge clk_in) begin
        if (!redirect && !stall) begin
            pc <= pcReg;
        end
    end

    // grab the word on the first stalled cycle only
    always_ff @(posedge clk_in) begin
        if (stall && !held) begin
            instrHold <= imemData;
        end
    end

endmodule

//--- hw/stageRegister.sv
`timescale 1ns/1ps

module stageRegister #(
    parameter type payloadT = logic
) (
    input logic clk_in,
    input logic rst_in,
    input logic hold,
    input logic flush,
    input payloadT dataIn,
    input logic validIn,
    output payloadT dataOut,
    output logic validOut
);

    // valid tag, hold beats flush
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            validOut <= 1'b0;
        end else if (!hold) begin
            validOut <= validIn & ~flush;
        end
    end

    // payload only moves with the tag
    always_ff @(posedge clk_in) begin
        if (!hold) begin
            dataOut <= dataIn;
        end
    end

endmodule

//--- hw/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [`REG_IDX_W-1:0] regIdxT;

    // instruction class
    typedef enum logic [2:0] {
        ALU, ALUI, BRANCH, JAL, LOAD, STORE, UNSUPPORTED
    } iTypeT;

    // alu operation, NOPA when the alu is unused
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, NOPA
    } aluFuncT;

    // branch condition
    typedef enum logic [1:0] {
        EQ, NE, NOPB
    } brFuncT;

    // unused sources and dst stay at x0
    typedef struct packed {
        iTypeT iType;
        aluFuncT aluFunc;
        brFuncT brFunc;
        regIdxT dst;
        regIdxT src1;
        regIdxT src2;
        wordT imm;
    } decodedInstT;

    // decode to execute payload
    typedef struct packed {
        wordT pc;
        decodedInstT dInst;
        wordT rVal1;
        wordT rVal2;
    } d2eT;

    // execute to writeback payload
    // data is the result, or the store data for STORE
    typedef struct packed {
        wordT pc;
        iTypeT iType;
        regIdxT dst;
        wordT data;
        wordT addr;
    } e2wT;

endpackage

//--- hw/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath width
`define XLEN 32

// register index width and count
`define REG_IDX_W 5
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
